//--- hw/cpu_pkg.sv
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    // instruction address, low two bits always zero
    typedef logic [31:0] pc_t;

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_slt,
        alu_sltu
    } alu_op_t;

    typedef enum logic [2:0] {
        st_fetch,
        st_fetch_wait,
        st_decode,
        st_execute,
        st_execute_wait,
        st_write
    } core_state_t;

    // everything execute needs from one instruction
    typedef struct packed {
        logic       is_alu;
        logic       is_lui;
        logic       is_load;
        logic       is_store;
        logic       is_branch;
        logic       is_jal;
        logic       is_jalr;
        alu_op_t    alu_op;
        logic       use_imm;
        logic [2:0] funct3;
        reg_addr_t  rd;
        word_t      rs1_val;
        word_t      rs2_val;
        word_t      imm;
    } decoded_t;

    localparam pc_t reset_pc = 32'h0000_0000;

endpackage

//--- hw/bus_pkg.sv
package bus_pkg;

    // outstanding-request credits per port
    typedef logic [1:0] credit_t;

    // one-cycle request, valid high for exactly one cycle
    typedef struct packed {
        logic        valid;
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  strb;
    } mem_req_t;

    // one response per request, also hands the credit back
    typedef struct packed {
        logic        valid;
        logic [31:0] rdata;
    } mem_rsp_t;

    localparam credit_t port_credits = 2'd1;

endpackage

//--- hw/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic               clk,
    input  logic               rstn,
    input  logic               we,
    input  cpu_pkg::reg_addr_t rd,
    input  cpu_pkg::word_t     rd_val,
    input  cpu_pkg::reg_addr_t rs1,
    input  cpu_pkg::reg_addr_t rs2,
    output cpu_pkg::word_t     rs1_val,
    output cpu_pkg::word_t     rs2_val
);

    cpu_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != '0)) begin
            regs[rd] <= rd_val;
        end
    end

    // x0 is hardwired to zero
    assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- hw/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
    input  logic              clk,
    input  logic              rstn,
    input  logic              order,
    input  cpu_pkg::pc_t      pc,
    output logic              fetched,
    output cpu_pkg::word_t    inst,
    output bus_pkg::mem_req_t imem_req,
    input  bus_pkg::mem_rsp_t imem_rsp
);

    bus_pkg::credit_t credits;
    logic             issue;
    logic             req_valid;
    cpu_pkg::pc_t     req_addr;

    // credit is taken when the request is decided
    assign issue = order && (credits != '0);

    assign imem_req = '{valid: req_valid, write: 1'b0, addr: req_addr, wdata: '0, strb: '0};

    always_ff @(posedge clk) begin
        if (!rstn) begin
            credits   <= bus_pkg::port_credits;
            req_valid <= 1'b0;
            fetched   <= 1'b0;
        end else begin
            credits   <= credits - 2'(issue) + 2'(imem_rsp.valid);
            req_valid <= issue;
            fetched   <= imem_rsp.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            req_addr <= pc;
        end
        if (imem_rsp.valid) begin
            inst <= imem_rsp.rdata;
        end
    end

    // the core orders a fetch only after the previous one came back
    a_order_credit: assert property (@(posedge clk) disable iff (!rstn)
        order |-> credits != '0);

    a_fetch_aligned: assert property (@(posedge clk) disable iff (!rstn)
        imem_req.valid |-> imem_req.addr[1:0] == 2'b00);

endmodule

//--- hw/decoder.sv
`timescale 1ns/1ps

module decoder (
    input  cpu_pkg::word_t     inst,
    output cpu_pkg::reg_addr_t rs1,
    output cpu_pkg::reg_addr_t rs2,
    input  cpu_pkg::word_t     rs1_val,
    input  cpu_pkg::word_t     rs2_val,
    output cpu_pkg::decoded_t  dec
);

    cpu_pkg::opcode_t opcode;
    logic [2:0]       funct3;
    logic             f7b5;
    cpu_pkg::word_t   imm_i;
    cpu_pkg::word_t   imm_s;
    cpu_pkg::word_t   imm_b;
    cpu_pkg::word_t   imm_u;
    cpu_pkg::word_t   imm_j;

    // register form uses funct7 bit 5 for sub, immediate form does not
    function automatic cpu_pkg::alu_op_t map_alu(input logic [2:0] f3, input logic alt,
                                                 input logic reg_form);
        case (f3)
            3'b000:  map_alu = (alt && reg_form) ? cpu_pkg::alu_sub : cpu_pkg::alu_add;
            3'b001:  map_alu = cpu_pkg::alu_sll;
            3'b010:  map_alu = cpu_pkg::alu_slt;
            3'b011:  map_alu = cpu_pkg::alu_sltu;
            3'b100:  map_alu = cpu_pkg::alu_xor;
            3'b101:  map_alu = alt ? cpu_pkg::alu_sra : cpu_pkg::alu_srl;
            3'b110:  map_alu = cpu_pkg::alu_or;
            default: map_alu = cpu_pkg::alu_and;
        endcase
    endfunction

    assign opcode = cpu_pkg::opcode_t'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign f7b5   = inst[30];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        dec         = '0;
        dec.alu_op  = cpu_pkg::alu_add;
        dec.funct3  = funct3;
        dec.rd      = inst[11:7];
        dec.rs1_val = rs1_val;
        dec.rs2_val = rs2_val;
        case (opcode)
            cpu_pkg::opc_op: begin
                dec.is_alu = 1'b1;
                dec.alu_op = map_alu(funct3, f7b5, 1'b1);
            end
            cpu_pkg::opc_op_imm: begin
                dec.is_alu  = 1'b1;
                dec.use_imm = 1'b1;
                dec.alu_op  = map_alu(funct3, f7b5, 1'b0);
                dec.imm     = imm_i;
            end
            cpu_pkg::opc_lui: begin
                dec.is_lui = 1'b1;
                dec.imm    = imm_u;
            end
            cpu_pkg::opc_load: begin
                dec.is_load = 1'b1;
                dec.imm     = imm_i;
            end
            cpu_pkg::opc_store: begin
                dec.is_store = 1'b1;
                dec.imm      = imm_s;
            end
            cpu_pkg::opc_branch: begin
                dec.is_branch = 1'b1;
                dec.imm       = imm_b;
            end
            cpu_pkg::opc_jal: begin
                dec.is_jal = 1'b1;
                dec.imm    = imm_j;
            end
            cpu_pkg::opc_jalr: begin
                dec.is_jalr = 1'b1;
                dec.imm     = imm_i;
            end
            // unknown opcode falls through as a no-op
            default: ;
        endcase
    end

endmodule

//--- hw/alu.sv
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::alu_op_t op,
    input  cpu_pkg::word_t   a,
    input  cpu_pkg::word_t   b,
    input  logic [2:0]       funct3,
    output cpu_pkg::word_t   result,
    output logic             branch_taken
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            cpu_pkg::alu_add:  result = a + b;
            cpu_pkg::alu_sub:  result = a - b;
            cpu_pkg::alu_and:  result = a & b;
            cpu_pkg::alu_or:   result = a | b;
            cpu_pkg::alu_xor:  result = a ^ b;
            cpu_pkg::alu_sll:  result = a << shamt;
            cpu_pkg::alu_srl:  result = a >> shamt;
            cpu_pkg::alu_sra:  result = $signed(a) >>> shamt;
            cpu_pkg::alu_slt:  result = {31'b0, $signed(a) < $signed(b)};
            cpu_pkg::alu_sltu: result = {31'b0, a < b};
            default:           result = '0;
        endcase
    end

    // beq, bne, blt, bge
    always_comb begin
        case (funct3)
            3'b000:  branch_taken = (a == b);
            3'b001:  branch_taken = (a != b);
            3'b100:  branch_taken = ($signed(a) < $signed(b));
            3'b101:  branch_taken = ($signed(a) >= $signed(b));
            default: branch_taken = 1'b0;
        endcase
    end

endmodule

//--- hw/load_store_unit.sv
`timescale 1ns/1ps

module load_store_unit (
    input  logic              clk,
    input  logic              rstn,
    input  logic              order,
    input  cpu_pkg::decoded_t dec,
    output logic              done,
    output cpu_pkg::word_t    load_val,
    output bus_pkg::mem_req_t dmem_req,
    input  bus_pkg::mem_rsp_t dmem_rsp
);

    bus_pkg::credit_t  credits;
    logic              issue;
    cpu_pkg::word_t    addr;
    cpu_pkg::word_t    wdata;
    logic [3:0]        strb;
    bus_pkg::mem_req_t req_q;
    logic [7:0]        load_byte;

    assign issue = order && (credits != '0);
    assign addr  = dec.rs1_val + dec.imm;

    always_comb begin
        if (dec.funct3 == 3'b000) begin
            // sb, byte copied to every lane
            strb  = 4'b0001 << addr[1:0];
            wdata = {4{dec.rs2_val[7:0]}};
        end else begin
            strb  = 4'b1111;
            wdata = dec.rs2_val;
        end
        if (!dec.is_store) begin
            strb = 4'b0000;
        end
    end

    assign dmem_req  = req_q;
    assign load_byte = dmem_rsp.rdata[{req_q.addr[1:0], 3'b000} +: 8];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            credits     <= bus_pkg::port_credits;
            req_q.valid <= 1'b0;
            done        <= 1'b0;
        end else begin
            credits     <= credits - 2'(issue) + 2'(dmem_rsp.valid);
            req_q.valid <= issue;
            done        <= dmem_rsp.valid;
        end
        if (issue) begin
            req_q.write <= dec.is_store;
            req_q.addr  <= addr;
            req_q.wdata <= wdata;
            req_q.strb  <= strb;
        end
    end

    // lbu zero-extends, lw passes the word
    always_ff @(posedge clk) begin
        if (dmem_rsp.valid) begin
            load_val <= (dec.funct3 == 3'b100) ? {24'b0, load_byte} : dmem_rsp.rdata;
        end
    end

    a_word_aligned: assert property (@(posedge clk) disable iff (!rstn)
        dmem_req.valid && dec.funct3 == 3'b010 |-> dmem_req.addr[1:0] == 2'b00);

    // the core waits for done before it can order again
    a_order_credit: assert property (@(posedge clk) disable iff (!rstn)
        order |-> credits != '0);

endmodule

//--- hw/cpu_core.sv
`timescale 1ns/1ps

module cpu_core (
    input  logic              clk,
    input  logic              rstn,
    output bus_pkg::mem_req_t imem_req,
    input  bus_pkg::mem_rsp_t imem_rsp,
    output bus_pkg::mem_req_t dmem_req,
    input  bus_pkg::mem_rsp_t dmem_rsp
);

    cpu_pkg::core_state_t state;
    cpu_pkg::pc_t         pc;

    // fetch to decode
    cpu_pkg::word_t       inst_fd;
    cpu_pkg::pc_t         pc_fd;
    // decode to execute
    cpu_pkg::decoded_t    dec_d;
    cpu_pkg::decoded_t    dec_de;
    cpu_pkg::pc_t         pc_de;
    // execute to write
    logic                 write_ew;
    cpu_pkg::reg_addr_t   rd_ew;
    cpu_pkg::word_t       d_rd_ew;
    cpu_pkg::pc_t         next_pc_ew;

    logic                 fetch_order;
    logic                 fetched;
    cpu_pkg::word_t       inst_f;
    cpu_pkg::reg_addr_t   rs1_addr;
    cpu_pkg::reg_addr_t   rs2_addr;
    cpu_pkg::word_t       rs1_val;
    cpu_pkg::word_t       rs2_val;
    cpu_pkg::word_t       alu_b;
    cpu_pkg::word_t       alu_result;
    logic                 branch_taken;
    logic                 is_mem;
    logic                 lsu_order;
    logic                 lsu_done;
    cpu_pkg::word_t       load_val;
    logic                 wb_en;
    cpu_pkg::word_t       wb_val;
    cpu_pkg::pc_t         pc_plus4;
    cpu_pkg::pc_t         next_pc;

    assign fetch_order = (state == cpu_pkg::st_fetch);
    assign is_mem      = dec_de.is_load || dec_de.is_store;
    assign lsu_order   = (state == cpu_pkg::st_execute) && is_mem;
    assign alu_b       = dec_de.use_imm ? dec_de.imm : dec_de.rs2_val;
    assign pc_plus4    = pc_de + 32'd4;
    assign wb_en       = dec_de.is_alu || dec_de.is_lui || dec_de.is_load
                      || dec_de.is_jal || dec_de.is_jalr;

    reg_file reg_file_i (
        .clk(clk), .rstn(rstn), .we((state == cpu_pkg::st_write) && write_ew),
        .rd(rd_ew), .rd_val(d_rd_ew), .rs1(rs1_addr), .rs2(rs2_addr),
        .rs1_val(rs1_val), .rs2_val(rs2_val));

    fetch_unit fetch_i (
        .clk(clk), .rstn(rstn), .order(fetch_order), .pc(pc), .fetched(fetched),
        .inst(inst_f), .imem_req(imem_req), .imem_rsp(imem_rsp));

    decoder decoder_i (
        .inst(inst_fd), .rs1(rs1_addr), .rs2(rs2_addr),
        .rs1_val(rs1_val), .rs2_val(rs2_val), .dec(dec_d));

    alu alu_i (
        .op(dec_de.alu_op), .a(dec_de.rs1_val), .b(alu_b), .funct3(dec_de.funct3),
        .result(alu_result), .branch_taken(branch_taken));

    load_store_unit lsu_i (
        .clk(clk), .rstn(rstn), .order(lsu_order), .dec(dec_de), .done(lsu_done),
        .load_val(load_val), .dmem_req(dmem_req), .dmem_rsp(dmem_rsp));

    // next pc and write-back value, used in execute
    always_comb begin
        next_pc = pc_plus4;
        wb_val  = alu_result;
        if (dec_de.is_branch && branch_taken) begin
            next_pc = pc_de + dec_de.imm;
        end
        if (dec_de.is_jal) begin
            next_pc = pc_de + dec_de.imm;
        end
        if (dec_de.is_jalr) begin
            next_pc = (dec_de.rs1_val + dec_de.imm) & ~32'd1;
        end
        if (dec_de.is_lui) begin
            wb_val = dec_de.imm;
        end
        if (dec_de.is_jal || dec_de.is_jalr) begin
            wb_val = pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state    <= cpu_pkg::st_fetch;
            pc       <= cpu_pkg::reset_pc;
            write_ew <= 1'b0;
        end else begin
            case (state)
                cpu_pkg::st_fetch: state <= cpu_pkg::st_fetch_wait;
                cpu_pkg::st_fetch_wait: begin
                    if (fetched) begin
                        state <= cpu_pkg::st_decode;
                    end
                end
                cpu_pkg::st_decode: state <= cpu_pkg::st_execute;
                cpu_pkg::st_execute: begin
                    write_ew <= wb_en;
                    state    <= is_mem ? cpu_pkg::st_execute_wait : cpu_pkg::st_write;
                end
                cpu_pkg::st_execute_wait: begin
                    if (lsu_done) begin
                        state <= cpu_pkg::st_write;
                    end
                end
                cpu_pkg::st_write: begin
                    pc    <= {next_pc_ew[31:2], 2'b00};
                    state <= cpu_pkg::st_fetch;
                end
                default: state <= cpu_pkg::st_fetch;
            endcase
        end
    end

    // stage registers
    always_ff @(posedge clk) begin
        if ((state == cpu_pkg::st_fetch_wait) && fetched) begin
            inst_fd <= inst_f;
            pc_fd   <= pc;
        end
        if (state == cpu_pkg::st_decode) begin
            dec_de <= dec_d;
            pc_de  <= pc_fd;
        end
        if (state == cpu_pkg::st_execute) begin
            rd_ew      <= dec_de.rd;
            d_rd_ew    <= wb_val;
            next_pc_ew <= next_pc;
        end
        if ((state == cpu_pkg::st_execute_wait) && lsu_done && dec_de.is_load) begin
            d_rd_ew <= load_val;
        end
    end

    a_state_legal: assert property (@(posedge clk) disable iff (!rstn)
        state inside {cpu_pkg::st_fetch, cpu_pkg::st_fetch_wait, cpu_pkg::st_decode,
                      cpu_pkg::st_execute, cpu_pkg::st_execute_wait, cpu_pkg::st_write});

endmodule

//--- tb/tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model #(
    parameter int seed = 1
) (
    input  logic              clk,
    input  bus_pkg::mem_req_t imem_req,
    output bus_pkg::mem_rsp_t imem_rsp,
    input  bus_pkg::mem_req_t dmem_req,
    output bus_pkg::mem_rsp_t dmem_rsp
);

    localparam int depth = 256;

    // word arrays, indexed by addr[9:2]
    logic [31:0] imem [depth];
    logic [31:0] dmem [depth];

    int          i_wait;
    int          d_wait;
    logic [31:0] i_data;
    logic [31:0] d_data;

    function automatic logic [31:0] apply_strobes(input logic [31:0] old,
                                                  input logic [31:0] wdata,
                                                  input logic [3:0]  strb);
        logic [31:0] merged;
        merged = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                merged[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return merged;
    endfunction

    // one request per port at a time, answered 1 to 4 cycles later
    initial begin
        void'($urandom(seed));
        imem_rsp = '0;
        dmem_rsp = '0;
        i_wait   = 0;
        d_wait   = 0;
        forever begin
            @(posedge clk);
            #2;
            imem_rsp.valid = 1'b0;
            dmem_rsp.valid = 1'b0;
            if (i_wait > 0) begin
                i_wait--;
                if (i_wait == 0) begin
                    imem_rsp = '{valid: 1'b1, rdata: i_data};
                end
            end
            if (d_wait > 0) begin
                d_wait--;
                if (d_wait == 0) begin
                    dmem_rsp = '{valid: 1'b1, rdata: d_data};
                end
            end
            if (imem_req.valid) begin
                i_data = imem[imem_req.addr[9:2]];
                i_wait = 1 + ($urandom % 4);
            end
            if (dmem_req.valid) begin
                if (dmem_req.write) begin
                    dmem[dmem_req.addr[9:2]] = apply_strobes(dmem[dmem_req.addr[9:2]],
                                                             dmem_req.wdata, dmem_req.strb);
                end
                d_data = dmem[dmem_req.addr[9:2]];
                d_wait = 1 + ($urandom % 4);
            end
        end
    end

endmodule

//--- tb/tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;

    localparam int timeout_cycles = 2000;

    logic              clk;
    logic              rstn;
    bus_pkg::mem_req_t imem_req;
    bus_pkg::mem_rsp_t imem_rsp;
    bus_pkg::mem_req_t dmem_req;
    bus_pkg::mem_rsp_t dmem_rsp;

    int          value_errors;
    int          bus_errors;
    int          prog_len;
    logic        timed_out;
    logic        i_pending;
    logic        d_pending;
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [3:0]  exp_strb [$];

    cpu_core dut_i (
        .clk(clk), .rstn(rstn), .imem_req(imem_req), .imem_rsp(imem_rsp),
        .dmem_req(dmem_req), .dmem_rsp(dmem_rsp));

    tb_mem_model #(.seed(28)) mem_i (
        .clk(clk), .imem_req(imem_req), .imem_rsp(imem_rsp),
        .dmem_req(dmem_req), .dmem_rsp(dmem_rsp));

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // instruction formats
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [6:0] opc, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [31:0] imm);
        return {imm[11:0], rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [2:0] f3, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [31:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [31:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] u_type(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [31:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic emit(input logic [31:0] inst);
        mem_i.imem[prog_len] = inst;
        prog_len++;
    endtask

    // every word is tagged with its own address
    // code words keep opcode 0, which the core skips as a no-op
    task automatic fill_memories();
        for (int i = 0; i < 256; i++) begin
            mem_i.imem[i] = 32'(i * 4) << 7;
            mem_i.dmem[i] = (i * 4) ^ 32'hC3C3_0000;
        end
    endtask

    task automatic load_program();
        prog_len = 0;
        emit(i_type(cpu_pkg::opc_op_imm, 3'b000, 5'd1, 5'd0, 256));
        emit(i_type(cpu_pkg::opc_op_imm, 3'b000, 5'd2, 5'd0, -100));
        emit(i_type(cpu_pkg::opc_op_imm, 3'b000, 5'd3, 5'd0, 2));
        emit(r_type(7'h20, 3'b000, 5'd4, 5'd2, 5'd3));
        emit(s_type(3'b010, 5'd4, 5'd1, 0));
        emit(r_type(7'h20, 3'b101, 5'd5, 5'd2, 5'd3));
        emit(s_type(3'b010, 5'd5, 5'd1, 4));
        emit(r_type(7'h00, 3'b011, 5'd6, 5'd3, 5'd2));
        emit(u_type(5'd7, 20'h12345));
        emit(r_type(7'h00, 3'b110, 5'd6, 5'd6, 5'd7));
        emit(s_type(3'b010, 5'd6, 5'd1, 8));
        // x0 must stay zero
        emit(i_type(cpu_pkg::opc_op_imm, 3'b000, 5'd0, 5'd0, 55));
        emit(s_type(3'b010, 5'd0, 5'd1, 12));
        // byte lanes 1 and 3 of word 0x110
        emit(i_type(cpu_pkg::opc_op_imm, 3'b000, 5'd8, 5'd0, 32'hA5));
        emit(s_type(3'b000, 5'd8, 5'd1, 17));
        emit(i_type(cpu_pkg::opc_op_imm, 3'b000, 5'd9, 5'd0, 32'h7E));
        emit(s_type(3'b000, 5'd9, 5'd1, 19));
        emit(i_type(cpu_pkg::opc_load, 3'b100, 5'd10, 5'd1, 17));
        emit(s_type(3'b010, 5'd10, 5'd1, 20));
        emit(i_type(cpu_pkg::opc_load, 3'b010, 5'd11, 5'd1, 16));
        emit(s_type(3'b010, 5'd11, 5'd1, 24));
        // every taken branch skips a store of x2
        emit(b_type(3'b000, 5'd3, 5'd3, 8));
        emit(s_type(3'b010, 5'd2, 5'd1, 28));
        emit(b_type(3'b000, 5'd3, 5'd2, 8));
        emit(s_type(3'b010, 5'd3, 5'd1, 28));
        emit(b_type(3'b001, 5'd3, 5'd2, 8));
        emit(s_type(3'b010, 5'd2, 5'd1, 32));
        emit(b_type(3'b001, 5'd3, 5'd3, 8));
        emit(s_type(3'b010, 5'd4, 5'd1, 32));
        emit(b_type(3'b100, 5'd2, 5'd3, 8));
        emit(s_type(3'b010, 5'd2, 5'd1, 36));
        emit(b_type(3'b100, 5'd3, 5'd2, 8));
        emit(s_type(3'b010, 5'd5, 5'd1, 36));
        emit(b_type(3'b101, 5'd3, 5'd2, 8));
        emit(s_type(3'b010, 5'd2, 5'd1, 40));
        emit(b_type(3'b101, 5'd2, 5'd3, 8));
        emit(s_type(3'b010, 5'd6, 5'd1, 40));
        // jal at 0x94 and jalr at 0xa4 each skip one store
        emit(j_type(5'd12, 8));
        emit(s_type(3'b010, 5'd2, 5'd1, 44));
        emit(s_type(3'b010, 5'd12, 5'd1, 44));
        // jalr target 0xad loses bit 0
        emit(i_type(cpu_pkg::opc_op_imm, 3'b000, 5'd14, 5'd0, 32'hAD));
        emit(i_type(cpu_pkg::opc_jalr, 3'b000, 5'd13, 5'd14, 0));
        emit(s_type(3'b010, 5'd2, 5'd1, 48));
        emit(s_type(3'b010, 5'd13, 5'd1, 48));
        emit(j_type(5'd0, 0));
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] data,
                                input logic [3:0] strb);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
        exp_strb.push_back(strb);
    endtask

    task automatic expected_stores();
        expect_store(32'h100, 32'hFFFF_FF9A, 4'b1111);
        expect_store(32'h104, 32'hFFFF_FFE7, 4'b1111);
        expect_store(32'h108, 32'h1234_5001, 4'b1111);
        expect_store(32'h10C, 32'h0000_0000, 4'b1111);
        expect_store(32'h111, 32'hA5A5_A5A5, 4'b0010);
        expect_store(32'h113, 32'h7E7E_7E7E, 4'b1000);
        expect_store(32'h114, 32'h0000_00A5, 4'b1111);
        expect_store(32'h118, 32'h7EC3_A510, 4'b1111);
        expect_store(32'h11C, 32'h0000_0002, 4'b1111);
        expect_store(32'h120, 32'hFFFF_FF9A, 4'b1111);
        expect_store(32'h124, 32'hFFFF_FFE7, 4'b1111);
        expect_store(32'h128, 32'h1234_5001, 4'b1111);
        expect_store(32'h12C, 32'h0000_0098, 4'b1111);
        expect_store(32'h130, 32'h0000_00A8, 4'b1111);
    endtask

    // store requests are sampled at the falling edge
    task automatic wait_store(output logic seen);
        int cycles;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < timeout_cycles) begin
            @(negedge clk);
            seen = dmem_req.valid && dmem_req.write;
            cycles++;
        end
    endtask

    task automatic check_store();
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        addr = exp_addr.pop_front();
        data = exp_data.pop_front();
        strb = exp_strb.pop_front();
        a_store_addr: assert (dmem_req.addr == addr) else begin
            value_errors++;
            $display("CHECK FAILED dmem_req.addr: got %h, expected %h", dmem_req.addr, addr);
        end
        a_store_data: assert (dmem_req.wdata == data) else begin
            value_errors++;
            $display("CHECK FAILED dmem_req.wdata: got %h, expected %h", dmem_req.wdata, data);
        end
        a_store_strb: assert (dmem_req.strb == strb) else begin
            value_errors++;
            $display("CHECK FAILED dmem_req.strb: got %h, expected %h", dmem_req.strb, strb);
        end
    endtask

    // one outstanding request per port until its response
    always @(posedge clk) begin
        if (!rstn) begin
            i_pending <= 1'b0;
            d_pending <= 1'b0;
        end else begin
            if (imem_req.valid) begin
                i_pending <= 1'b1;
            end else if (imem_rsp.valid) begin
                i_pending <= 1'b0;
            end
            if (dmem_req.valid) begin
                d_pending <= 1'b1;
            end else if (dmem_rsp.valid) begin
                d_pending <= 1'b0;
            end
        end
    end

    a_idle_in_reset: assert property (@(posedge clk)
        !rstn |=> !imem_req.valid && !dmem_req.valid) else begin
        bus_errors++;
        $display("memory request went out during reset");
    end

    a_imem_single: assert property (@(posedge clk) disable iff (!rstn)
        imem_req.valid |-> !i_pending) else begin
        bus_errors++;
        $display("second fetch request sent before the first was answered");
    end

    a_dmem_single: assert property (@(posedge clk) disable iff (!rstn)
        dmem_req.valid |-> !d_pending) else begin
        bus_errors++;
        $display("second data request sent before the first was answered");
    end

    a_fetch_form: assert property (@(posedge clk) disable iff (!rstn)
        imem_req.valid |-> imem_req.addr[1:0] == 2'b00 && !imem_req.write
                           && imem_req.strb == 4'b0000) else begin
        bus_errors++;
        $display("fetch request misaligned or marked as a write");
    end

    a_fetch_after_data: assert property (@(posedge clk) disable iff (!rstn)
        imem_req.valid |-> !d_pending && !dmem_req.valid) else begin
        bus_errors++;
        $display("fetch request sent while a data request was still open");
    end

    initial begin
        logic seen;
        value_errors = 0;
        bus_errors   = 0;
        timed_out    = 1'b0;
        rstn         = 1'b0;
        fill_memories();
        load_program();
        expected_stores();
        repeat (10) @(posedge clk);
        #2;
        rstn = 1'b1;
        while (exp_addr.size() > 0 && !timed_out) begin
            wait_store(seen);
            if (!seen) begin
                timed_out = 1'b1;
                $display("no store within %0d cycles, %0d stores never seen",
                         timeout_cycles, exp_addr.size());
            end else begin
                check_store();
            end
        end
        $display("errors: %0d value, %0d bus rule, %0d timeout",
                 value_errors, bus_errors, timed_out);
        if (value_errors == 0 && bus_errors == 0 && !timed_out) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- flist.f
hw/cpu_pkg.sv
hw/bus_pkg.sv
hw/reg_file.sv
hw/fetch_unit.sv
hw/decoder.sv
hw/alu.sv
hw/load_store_unit.sv
hw/cpu_core.sv
tb/tb_mem_model.sv
tb/tb_cpu.sv
